// File: sifh.f
sifhPkg.sv
histRam.sv
hisBuilder.sv
peakFinder.sv
sifhControl.sv
sifhTop.sv
sifhTb.sv

// File: Bender.yml
package:
  name: sifh

sources:
  - sifhPkg.sv
  - histRam.sv
  - hisBuilder.sv
  - peakFinder.sv
  - sifhControl.sv
  - sifhTop.sv
  - target: test
    files:
      - sifhTb.sv

// File: sifhTb.sv
`default_nettype none

module sifhTb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int frameNum   = 8;
    localparam int frameLimit = 2 * sifhPkg::binNum + 2 * sifhPkg::hitNum + 20;
    localparam int runLimit   = frameNum * frameLimit;
    localparam int lowBits    = sifhPkg::tdcWidth - sifhPkg::binBits;

    localparam logic [sifhPkg::binBits-1:0] tieLow  = 6'd12; // must win the tie
    localparam logic [sifhPkg::binBits-1:0] tieHigh = 6'd40;

    logic                         clk = 1'b0;
    logic                         res;
    logic                         start;
    logic                         hitValid;
    logic [sifhPkg::tdcWidth-1:0] hitData;
    logic                         hitReady;
    logic                         done;
    sifhPkg::peakResult           peak;

    logic [sifhPkg::countWidth-1:0] model [sifhPkg::binNum]; // expected histogram
    sifhPkg::peakResult lastPeak = '0; // result of the previous frame
    int errors = 0;
    int checks = 0;
    int cycles = 0;

    sifhTop dut_i (
        .clk      (clk),
        .res      (res),
        .start    (start),
        .hitValid (hitValid),
        .hitData  (hitData),
        .hitReady (hitReady),
        .done     (done),
        .peak     (peak)
    );

    always #50 clk = ~clk;

    // run limit backstop
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= runLimit) begin
            $display("timeout: run still going after %0d cycles", cycles);
            $display("%0d checks, %0d errors", checks, errors + 1);
            $display("Test failures found");
            $finish;
        end
    end

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    // saturating increment, like the SRAM counts
    task automatic addHit(input logic [sifhPkg::binBits-1:0] bin);
        if (!(&model[bin])) begin
            model[bin] = model[bin] + 1'b1;
        end
    endtask

    // first maximum over all bins
    function automatic sifhPkg::peakResult expectedPeak();
        sifhPkg::peakResult best;
        best.bin   = '0;
        best.count = model[0];
        for (int b = 1; b < sifhPkg::binNum; b++) begin
            if (model[b] > best.count) begin
                best.bin   = sifhPkg::binBits'(b);
                best.count = model[b];
            end
        end
        return best;
    endfunction

    // bin choice per frame mode
    function automatic logic [sifhPkg::binBits-1:0] pickBin(
        input int mode, input int accepted, input logic [sifhPkg::binBits-1:0] focus);
        logic [sifhPkg::binBits-1:0] bin;
        case (mode)
            1: bin = focus;                                    // one bin only
            2: bin = accepted[0] ? tieLow : tieHigh;           // equal split
            3: bin = focus + sifhPkg::binBits'($urandom % 3); // a few bins
            default: bin = sifhPkg::binBits'($urandom);
        endcase
        return bin;
    endfunction

    task automatic runFrame(input int frame);
        int mode;
        int accepted;
        int waitCycles;
        bit midStart;
        bit pulsed;
        bit gotDone;
        logic [sifhPkg::binBits-1:0] focus;
        logic [sifhPkg::binBits-1:0] bin;
        sifhPkg::peakResult expPeak;

        mode       = frame % 4;
        midStart   = (frame >= 4); // later frames also get a stray start
        pulsed     = 1'b0;
        gotDone    = 1'b0;
        accepted   = 0;
        waitCycles = 0;
        focus      = sifhPkg::binBits'($urandom % sifhPkg::binNum);
        for (int b = 0; b < sifhPkg::binNum; b++) begin
            model[b] = '0;
        end

        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        while (!gotDone && waitCycles < frameLimit) begin
            @(negedge clk);
            waitCycles++;
            if (done) begin
                gotDone = 1'b1;
            end else begin
                checkValue("peak", peak, lastPeak); // held until the next done
                if (hitReady && accepted >= sifhPkg::hitNum) begin
                    errors++;
                    $display("hitReady still high after %0d accepted hits", accepted);
                end
                start = 1'b0;
                if (midStart && !pulsed && accepted == sifhPkg::hitNum / 2) begin
                    start  = 1'b1; // must be ignored
                    pulsed = 1'b1;
                end
                hitValid = (mode == 1) || (($urandom % 10) < 7);
                bin      = pickBin(mode, accepted, focus);
                hitData  = {bin, lowBits'($urandom)};
                if (hitValid && hitReady) begin // taken at the next rising edge
                    addHit(bin);
                    accepted++;
                end
            end
        end
        start    = 1'b0;
        hitValid = 1'b0;

        if (!gotDone) begin
            errors++;
            $display("frame %0d: done never arrived within %0d cycles", frame, frameLimit);
        end else begin
            expPeak = expectedPeak();
            checkValue("accepted hits", accepted, sifhPkg::hitNum);
            checkValue("peak.bin", peak.bin, expPeak.bin);
            checkValue("peak.count", peak.count, expPeak.count);
            if (mode == 1) begin
                checkValue("peak.count", peak.count, sifhPkg::hitNum); // no lost increments
            end
            if (mode == 2) begin
                checkValue("peak.bin", peak.bin, tieLow);
            end
            lastPeak = expPeak;
            @(negedge clk);
            checkValue("done", done, 1'b0); // one-cycle pulse
            checkValue("peak.count", peak.count, expPeak.count);
        end
    endtask

    initial begin
        void'($urandom(32'h2281_7d20));
        res      = 1'b0;
        start    = 1'b0;
        hitValid = 1'b0;
        hitData  = '0;
        repeat (16) @(negedge clk);
        res = 1'b1;

        // idle, offered hits must not be taken
        repeat (8) begin
            @(negedge clk);
            checkValue("hitReady", hitReady, 1'b0);
            checkValue("done", done, 1'b0);
            checkValue("peak", peak, '0);
            hitValid = ($urandom % 10) < 7;
            hitData  = sifhPkg::tdcWidth'($urandom);
        end
        hitValid = 1'b0;

        for (int f = 0; f < frameNum; f++) begin
            runFrame(f);
            repeat (3) @(negedge clk);
        end

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sifhTop.sv
`default_nettype none

module sifhTop (
    input  logic                         clk,
    input  logic                         res,
    input  logic                         start,
    input  logic                         hitValid,
    input  logic [sifhPkg::tdcWidth-1:0] hitData,
    output logic                         hitReady,
    output logic                         done,
    output sifhPkg::peakResult           peak
);

    sifhPkg::ramWrPort              ramWr;
    sifhPkg::ramRdPort              ramRd;
    sifhPkg::ramWrPort              builderWr;
    sifhPkg::ramRdPort              builderRd;
    sifhPkg::ramRdPort              finderRd;
    logic [sifhPkg::countWidth-1:0] rdData;   // shared by builder and finder
    logic                           buildEn;
    logic                           buildDone;
    logic                           scanStart;
    logic                           scanDone;

    histRam ram (
        .clk    (clk),
        .wr     (ramWr),
        .rd     (ramRd),
        .rdData (rdData)
    );

    hisBuilder builder (
        .clk       (clk),
        .res       (res),
        .buildEn   (buildEn),
        .hitValid  (hitValid),
        .hitData   (hitData),
        .rdData    (rdData),
        .hitReady  (hitReady),
        .wr        (builderWr),
        .rd        (builderRd),
        .buildDone (buildDone)
    );

    peakFinder finder (
        .clk       (clk),
        .res       (res),
        .scanStart (scanStart),
        .rdData    (rdData),
        .rd        (finderRd),
        .scanDone  (scanDone),
        .peak      (peak)
    );

    sifhControl control (
        .clk       (clk),
        .res       (res),
        .start     (start),
        .builderWr (builderWr),
        .builderRd (builderRd),
        .finderRd  (finderRd),
        .buildDone (buildDone),
        .scanDone  (scanDone),
        .buildEn   (buildEn),
        .scanStart (scanStart),
        .done      (done),
        .ramWr     (ramWr),
        .ramRd     (ramRd)
    );

endmodule

`default_nettype wire

// File: sifhControl.sv
`default_nettype none

module sifhControl (
    input  logic              clk,
    input  logic              res,
    input  logic              start,
    input  sifhPkg::ramWrPort builderWr,
    input  sifhPkg::ramRdPort builderRd,
    input  sifhPkg::ramRdPort finderRd,
    input  logic              buildDone,
    input  logic              scanDone,
    output logic              buildEn,
    output logic              scanStart,
    output logic              done,
    output sifhPkg::ramWrPort ramWr,
    output sifhPkg::ramRdPort ramRd
);

    sifhPkg::seqState            state;
    logic [sifhPkg::binBits-1:0] clrAddr;

    assign buildEn = (state == sifhPkg::seqBuild);
    assign done    = scanDone && (state == sifhPkg::seqFindPeak);

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state     <= sifhPkg::seqIdle;
            clrAddr   <= '0;
            scanStart <= 1'b0;
        end else begin
            scanStart <= 1'b0;
            case (state)
                sifhPkg::seqIdle: begin
                    if (start) begin // start elsewhere is ignored
                        state   <= sifhPkg::seqClear;
                        clrAddr <= '0;
                    end
                end
                sifhPkg::seqClear: begin
                    clrAddr <= clrAddr + 1'b1;
                    if (clrAddr == sifhPkg::lastBin) begin
                        state <= sifhPkg::seqBuild;
                    end
                end
                sifhPkg::seqBuild: begin
                    if (buildDone) begin
                        state     <= sifhPkg::seqFindPeak;
                        scanStart <= 1'b1;
                    end
                end
                sifhPkg::seqFindPeak: begin
                    if (scanDone) begin
                        state <= sifhPkg::seqIdle;
                    end
                end
                default: state <= sifhPkg::seqIdle;
            endcase
        end
    end

    // SRAM port owner per state
    always_comb begin
        ramWr = '0;
        ramRd = '0;
        case (state)
            sifhPkg::seqClear: begin
                ramWr = '{en: 1'b1, addr: clrAddr, data: '0};
            end
            sifhPkg::seqBuild: begin
                ramWr = builderWr;
                ramRd = builderRd;
            end
            sifhPkg::seqFindPeak: begin
                ramRd = finderRd;
            end
            default: begin
                ramWr = '0;
                ramRd = '0;
            end
        endcase
    end

    // scan reads must not overlap any SRAM write
    finderReadInScan: assert property (@(posedge clk) disable iff (!res)
        finderRd.en |-> (state == sifhPkg::seqFindPeak) && !ramWr.en)
        else $error("finder read outside the peak scan");

    builderWriteInBuild: assert property (@(posedge clk) disable iff (!res)
        builderWr.en |-> (state == sifhPkg::seqBuild))
        else $error("builder write outside the build phase");

endmodule

`default_nettype wire

// File: peakFinder.sv
`default_nettype none

module peakFinder (
    input  logic                           clk,
    input  logic                           res,
    input  logic                           scanStart,
    input  logic [sifhPkg::countWidth-1:0] rdData,
    output sifhPkg::ramRdPort              rd,
    output logic                           scanDone,
    output sifhPkg::peakResult             peak
);

    logic                           scanning;
    logic [sifhPkg::binBits-1:0]    rdAddr;    // next address to read
    logic                           dValid;    // rdData belongs to dBin
    logic [sifhPkg::binBits-1:0]    dBin;
    logic [sifhPkg::binBits-1:0]    bestBin;
    logic [sifhPkg::countWidth-1:0] bestCount;
    logic                           takeNew;
    logic [sifhPkg::binBits-1:0]    nextBin;
    logic [sifhPkg::countWidth-1:0] nextCount;

    // bin 0 is read in the scanStart cycle itself
    assign rd = '{en: scanStart || scanning, addr: scanning ? rdAddr : '0};

    // strictly greater only, lowest bin wins a tie
    assign takeNew   = (dBin == '0) || (rdData > bestCount);
    assign nextBin   = takeNew ? dBin : bestBin;
    assign nextCount = takeNew ? rdData : bestCount;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            scanning <= 1'b0;
            rdAddr   <= '0;
            dValid   <= 1'b0;
            scanDone <= 1'b0;
            peak     <= '0;
        end else begin
            if (scanStart) begin
                scanning <= 1'b1;
                rdAddr   <= sifhPkg::binBits'(1);
            end else if (scanning) begin
                rdAddr <= rdAddr + 1'b1;
                if (rdAddr == sifhPkg::lastBin) begin
                    scanning <= 1'b0;
                end
            end
            dValid   <= rd.en;
            scanDone <= dValid && (dBin == sifhPkg::lastBin);
            if (dValid && (dBin == sifhPkg::lastBin)) begin
                peak <= '{bin: nextBin, count: nextCount}; // held until the next scan ends
            end
        end
    end

    always_ff @(posedge clk) begin
        dBin <= rd.addr;
        if (dValid) begin
            bestBin   <= nextBin;
            bestCount <= nextCount;
        end
    end

    noRestart: assert property (@(posedge clk) disable iff (!res)
        scanStart |-> !(scanning || dValid))
        else $error("scanStart while a scan is running");

endmodule

`default_nettype wire

// File: hisBuilder.sv
`default_nettype none

module hisBuilder (
    input  logic                           clk,
    input  logic                           res,
    input  logic                           buildEn,
    input  logic                           hitValid,
    input  logic [sifhPkg::tdcWidth-1:0]   hitData,
    input  logic [sifhPkg::countWidth-1:0] rdData,
    output logic                           hitReady,
    output sifhPkg::ramWrPort              wr,
    output sifhPkg::ramRdPort              rd,
    output logic                           buildDone
);

    logic [sifhPkg::hitCntWidth-1:0] hitCnt;    // accepted hits this frame
    logic                            accept;
    logic [sifhPkg::binBits-1:0]     s0Bin;
    logic                            s1Valid;
    logic [sifhPkg::binBits-1:0]     s1Bin;
    logic                            fwdHit;
    logic [sifhPkg::countWidth-1:0]  fwdData;   // last count written
    logic [sifhPkg::countWidth-1:0]  curCount;
    logic [sifhPkg::countWidth-1:0]  nextCount;

    assign hitReady = buildEn && (hitCnt != sifhPkg::hitMax);
    assign accept   = hitValid && hitReady;

    // stage 0, coarse bin from the top of the timestamp
    assign s0Bin = hitData[sifhPkg::tdcWidth-1 -: sifhPkg::binBits];
    assign rd    = '{en: accept, addr: s0Bin};

    // stage 1
    // A hit read in the same cycle as a write to its bin got the old word
    // from the SRAM, so the value just written is taken instead.
    assign curCount  = fwdHit ? fwdData : rdData;
    assign nextCount = (&curCount) ? curCount : curCount + 1'b1; // saturate
    assign wr        = '{en: s1Valid, addr: s1Bin, data: nextCount};

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            hitCnt    <= '0;
            s1Valid   <= 1'b0;
            fwdHit    <= 1'b0;
            buildDone <= 1'b0;
        end else begin
            if (!buildEn) begin
                hitCnt <= '0; // ready for the next frame
            end else if (accept) begin
                hitCnt <= hitCnt + 1'b1;
            end
            s1Valid   <= accept;
            fwdHit    <= accept && s1Valid && (s0Bin == s1Bin);
            buildDone <= s1Valid && (hitCnt == sifhPkg::hitMax); // last write leaving
        end
    end

    always_ff @(posedge clk) begin
        s1Bin <= s0Bin;
        if (s1Valid) begin
            fwdData <= nextCount;
        end
    end

    hitCntBound: assert property (@(posedge clk) disable iff (!res)
        hitCnt <= sifhPkg::hitMax)
        else $error("hit count ran past hitNum");

    // the pipeline has drained before the build phase ends
    noStrayWrite: assert property (@(posedge clk) disable iff (!res)
        !buildEn |-> !wr.en)
        else $error("SRAM write outside the build phase");

endmodule

`default_nettype wire

// File: histRam.sv
`default_nettype none

module histRam (
    input  logic                           clk,
    input  sifhPkg::ramWrPort              wr,
    input  sifhPkg::ramRdPort              rd,
    output logic [sifhPkg::countWidth-1:0] rdData
);

    logic [sifhPkg::countWidth-1:0] mem [sifhPkg::binNum];

    // write port
    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // registered read, same-address collision returns the old word
    always_ff @(posedge clk) begin
        if (rd.en) begin
            rdData <= mem[rd.addr];
        end
    end

endmodule

`default_nettype wire

// File: sifhPkg.sv
`default_nettype none

package sifhPkg;

    // timestamp and histogram geometry
    localparam int tdcWidth   = 12;
    localparam int binBits    = 6;            // top timestamp bits used as bin index
    localparam int binNum     = 1 << binBits; // also the SRAM depth
    localparam int countWidth = 10;           // saturates at all ones

    // hits taken per frame
    localparam int hitNum      = 200;
    localparam int hitCntWidth = $clog2(hitNum + 1);

    // typed copies for compares against narrow counters
    localparam logic [binBits-1:0]     lastBin = binBits'(binNum - 1);
    localparam logic [hitCntWidth-1:0] hitMax  = hitCntWidth'(hitNum);

    typedef enum logic [1:0] {
        seqIdle,     // waiting for start
        seqClear,    // zeroing the SRAM
        seqBuild,    // accumulating hits
        seqFindPeak  // scanning for the highest bin
    } seqState;

    // SRAM write port
    typedef struct packed {
        logic                  en;
        logic [binBits-1:0]    addr;
        logic [countWidth-1:0] data;
    } ramWrPort;

    // SRAM read port, data comes back one cycle later
    typedef struct packed {
        logic               en;
        logic [binBits-1:0] addr;
    } ramRdPort;

    // reported peak
    typedef struct packed {
        logic [binBits-1:0]    bin;
        logic [countWidth-1:0] count;
    } peakResult;

endpackage

`default_nettype wire
